//--- verilog/soc_pkg.sv
package soc_pkg;

   //////////////////////////////////////////////////
   // Bus widths and memory map

   localparam int addr_width_c = 32;
   localparam int data_width_c = 32;

   localparam logic [addr_width_c-1:0] ram_base_c = 32'h2000_0000;
   localparam logic [addr_width_c-1:0] ram_mask_c = 32'hE000_0000;
   localparam logic [addr_width_c-1:0] tmr_base_c = 32'h4000_0400;
   localparam logic [addr_width_c-1:0] tmr_mask_c = 32'hFFFF_FFC0;   // 64 byte window

   //////////////////////////////////////////////////
   // AHB-Lite encodings

   typedef enum logic [1:0] {
      trans_idle   = 2'b00,
      trans_busy   = 2'b01,
      trans_nonseq = 2'b10,
      trans_seq    = 2'b11
   } htrans_e;

   typedef enum logic {
      resp_okay  = 1'b0,
      resp_error = 1'b1
   } hresp_e;

   typedef enum logic [2:0] {
      size_byte = 3'b000,
      size_half = 3'b001,
      size_word = 3'b010
   } hsize_e;

   // Timer word offsets, haddr[5:2]
   typedef enum logic [3:0] {
      tmr_ctrl    = 4'd0,
      tmr_count   = 4'd1,
      tmr_compare = 4'd2,
      tmr_status  = 4'd3
   } tmr_reg_e;

endpackage

//--- verilog/ahb_slave_if.sv
`timescale 1ns/1ps

interface ahb_slave_if;

   import soc_pkg::*;

   logic                    hsel;
   logic [addr_width_c-1:0] haddr;
   htrans_e                 htrans;
   logic                    hwrite;
   hsize_e                  hsize;
   logic [data_width_c-1:0] hwdata;
   logic                    hready;   // Bus-wide ready, from the decoder
   logic [data_width_c-1:0] hrdata;

   modport decoder (
      output hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
      input  hrdata
   );

   modport slave (
      input  hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
      output hrdata
   );

endinterface

//--- verilog/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
   input  logic                             hclk_i,
   input  logic                             rst_n_i,
   input  soc_pkg::htrans_e                 htrans_i,
   input  logic [soc_pkg::addr_width_c-1:0] haddr_i,
   input  logic                             hwrite_i,
   input  soc_pkg::hsize_e                  hsize_i,
   input  logic [soc_pkg::data_width_c-1:0] hwdata_i,
   output logic [soc_pkg::data_width_c-1:0] hrdata_o,
   output logic                             hready_o,
   output soc_pkg::hresp_e                  hresp_o,
   ahb_slave_if.decoder                     ram_o,
   ahb_slave_if.decoder                     tmr_o
);

   import soc_pkg::*;

   typedef enum logic [1:0] {tgt_none, tgt_ram, tgt_tmr, tgt_unmapped} target_e;
   typedef enum logic [1:0] {def_idle, def_err_first, def_err_second} def_state_e;

   logic       active;
   logic       ram_hit;
   logic       tmr_hit;
   logic       unmapped;
   target_e    target_q;
   def_state_e state_q;
   def_state_e state_d;

   //////////////////////////////////////////////////
   // Address phase decode

   assign active   = (htrans_i == trans_nonseq) || (htrans_i == trans_seq);
   assign ram_hit  = (haddr_i & ram_mask_c) == ram_base_c;
   assign tmr_hit  = (haddr_i & tmr_mask_c) == tmr_base_c;
   assign unmapped = active && !ram_hit && !tmr_hit;

   assign ram_o.hsel   = ram_hit;
   assign ram_o.haddr  = haddr_i;
   assign ram_o.htrans = htrans_i;
   assign ram_o.hwrite = hwrite_i;
   assign ram_o.hsize  = hsize_i;
   assign ram_o.hwdata = hwdata_i;
   assign ram_o.hready = hready_o;

   assign tmr_o.hsel   = tmr_hit;
   assign tmr_o.haddr  = haddr_i;
   assign tmr_o.htrans = htrans_i;
   assign tmr_o.hwrite = hwrite_i;
   assign tmr_o.hsize  = hsize_i;
   assign tmr_o.hwdata = hwdata_i;
   assign tmr_o.hready = hready_o;

   // Data phase owner, held while stalled
   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         target_q <= tgt_none;
      end else if (hready_o) begin
         if (!active)
            target_q <= tgt_none;
         else if (ram_hit)
            target_q <= tgt_ram;
         else if (tmr_hit)
            target_q <= tgt_tmr;
         else
            target_q <= tgt_unmapped;
      end
   end

   always_comb begin
      case (target_q)
         tgt_ram: hrdata_o = ram_o.hrdata;
         tgt_tmr: hrdata_o = tmr_o.hrdata;
         default: hrdata_o = '0;   // Nothing to return
      endcase
   end

   //////////////////////////////////////////////////
   // Default slave, two cycle ERROR

   always_comb begin
      state_d = def_idle;
      if (state_q == def_err_first)
         state_d = def_err_second;
      else if (hready_o && unmapped)
         state_d = def_err_first;
   end

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         state_q <= def_idle;
      else
         state_q <= state_d;
   end

   assign hready_o = (state_q != def_err_first);
   assign hresp_o  = (state_q == def_idle) ? resp_okay : resp_error;

endmodule

//--- verilog/ahb_sram.sv
`timescale 1ns/1ps

module ahb_sram #(
   parameter int ram_depth_words = 512   // Power of two
) (
   input  logic       hclk_i,
   input  logic       rst_n_i,
   ahb_slave_if.slave bus_i
);

   import soc_pkg::*;

   localparam int idx_w_c = $clog2(ram_depth_words);

   logic [data_width_c-1:0] mem [ram_depth_words];

   logic               accept;
   logic               wr_q;
   logic [idx_w_c-1:0] idx_q;
   logic [1:0]         lane_q;
   hsize_e             size_q;
   logic [3:0]         be;

   assign accept = bus_i.hsel && bus_i.hready &&
                   ((bus_i.htrans == trans_nonseq) || (bus_i.htrans == trans_seq));

   //////////////////////////////////////////////////
   // Address phase capture

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         wr_q <= 1'b0;
      else if (bus_i.hready)
         wr_q <= accept && bus_i.hwrite;
   end

   always_ff @(posedge hclk_i) begin
      if (accept) begin
         idx_q  <= bus_i.haddr[idx_w_c+1:2];   // Wraps at the depth
         lane_q <= bus_i.haddr[1:0];
         size_q <= bus_i.hsize;
      end
   end

   //////////////////////////////////////////////////
   // Data phase

   always_comb begin
      case (size_q)
         size_byte: be = 4'b0001 << lane_q;
         size_half: be = lane_q[1] ? 4'b1100 : 4'b0011;
         default:   be = 4'b1111;
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (wr_q) begin
         for (int i = 0; i < 4; i++) begin
            if (be[i])
               mem[idx_q][8*i +: 8] <= bus_i.hwdata[8*i +: 8];
         end
      end
   end

   // Zero wait read
   assign bus_i.hrdata = mem[idx_q];

endmodule

//--- verilog/ahb_timer.sv
`timescale 1ns/1ps

module ahb_timer (
   input  logic       hclk_i,
   input  logic       rst_n_i,
   ahb_slave_if.slave bus_i,
   output logic       tint_o
);

   import soc_pkg::*;

   logic                    accept;
   logic                    wr_q;
   tmr_reg_e                reg_q;
   logic                    match;
   logic [data_width_c-1:0] ctrl_q;
   logic [data_width_c-1:0] ctrl_d;
   logic [data_width_c-1:0] count_q;
   logic [data_width_c-1:0] compare_q;
   logic                    status_q;
   logic                    status_d;

   assign accept = bus_i.hsel && bus_i.hready &&
                   ((bus_i.htrans == trans_nonseq) || (bus_i.htrans == trans_seq));

   //////////////////////////////////////////////////
   // Address phase capture

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         wr_q <= 1'b0;
      else if (bus_i.hready)
         wr_q <= accept && bus_i.hwrite;
   end

   always_ff @(posedge hclk_i) begin
      if (accept)
         reg_q <= tmr_reg_e'(bus_i.haddr[5:2]);
   end

   //////////////////////////////////////////////////
   // Registers

   assign match = ctrl_q[0] && (count_q == compare_q);

   always_comb begin
      ctrl_d   = ctrl_q;
      status_d = status_q;
      if (wr_q && (reg_q == tmr_ctrl))
         ctrl_d = bus_i.hwdata;
      if (match)
         status_d = 1'b1;   // Match beats a clear
      else if (wr_q && (reg_q == tmr_status) && bus_i.hwdata[0])
         status_d = 1'b0;
   end

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q    <= '0;
         count_q   <= '0;
         compare_q <= '0;
         status_q  <= 1'b0;
         tint_o    <= 1'b0;
      end else begin
         ctrl_q   <= ctrl_d;
         status_q <= status_d;
         tint_o   <= status_d && ctrl_d[1];

         if (wr_q && (reg_q == tmr_count))
            count_q <= bus_i.hwdata;   // Load wins over counting
         else if (ctrl_q[0])
            count_q <= count_q + 1'b1;

         if (wr_q && (reg_q == tmr_compare))
            compare_q <= bus_i.hwdata;
      end
   end

   //////////////////////////////////////////////////
   // Read back

   always_comb begin
      case (reg_q)
         tmr_ctrl:    bus_i.hrdata = ctrl_q;
         tmr_count:   bus_i.hrdata = count_q;
         tmr_compare: bus_i.hrdata = compare_q;
         tmr_status:  bus_i.hrdata = {{(data_width_c-1){1'b0}}, status_q};
         default:     bus_i.hrdata = '0;   // Reserved offsets
      endcase
   end

endmodule

//--- verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
   parameter int ram_depth_words = 512
) (
   input  logic                             hclk_i,
   input  logic                             rst_n_i,
   input  soc_pkg::htrans_e                 htrans_i,
   input  logic [soc_pkg::addr_width_c-1:0] haddr_i,
   input  logic                             hwrite_i,
   input  soc_pkg::hsize_e                  hsize_i,
   input  logic [soc_pkg::data_width_c-1:0] hwdata_i,
   output logic [soc_pkg::data_width_c-1:0] hrdata_o,
   output logic                             hready_o,
   output soc_pkg::hresp_e                  hresp_o,
   output logic                             irq_o
);

   //////////////////////////////////////////////////
   // Slave channels

   ahb_slave_if ram_bus ();
   ahb_slave_if tmr_bus ();

   //////////////////////////////////////////////////
   // Fabric

   ahb_decoder decoder_i (
      .hclk_i   ( hclk_i   ),
      .rst_n_i  ( rst_n_i  ),
      .htrans_i ( htrans_i ),
      .haddr_i  ( haddr_i  ),
      .hwrite_i ( hwrite_i ),
      .hsize_i  ( hsize_i  ),
      .hwdata_i ( hwdata_i ),
      .hrdata_o ( hrdata_o ),
      .hready_o ( hready_o ),
      .hresp_o  ( hresp_o  ),
      .ram_o    ( ram_bus  ),
      .tmr_o    ( tmr_bus  )
   );

   // RAM region
   ahb_sram #(
      .ram_depth_words ( ram_depth_words )
   ) sram_i (
      .hclk_i          ( hclk_i          ),
      .rst_n_i         ( rst_n_i         ),
      .bus_i           ( ram_bus         )
   );

   // Timer region, interrupt straight out
   ahb_timer timer_i (
      .hclk_i  ( hclk_i  ),
      .rst_n_i ( rst_n_i ),
      .bus_i   ( tmr_bus ),
      .tint_o  ( irq_o   )
   );

endmodule

//--- verif/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top;

   import soc_pkg::*;

   localparam int          ram_depth_c  = 512;
   localparam int          max_cycles_c = 6000;   // About 400 transfers plus timer waits
   localparam logic [31:0] idx_mask_c   = (ram_depth_c - 1) << 2;   // RAM word index bits

   logic        hclk;
   logic        rst_n;
   htrans_e     htrans;
   logic [31:0] haddr;
   logic        hwrite;
   hsize_e      hsize;
   logic [31:0] hwdata;
   logic [31:0] hrdata;
   logic        hready;
   hresp_e      hresp;
   logic        irq;

   int          checks;
   int          errors;
   int          cycles;
   logic [31:0] ram_m [int];   // Word model by index
   logic [31:0] ram_addrs [$];
   logic [31:0] rd_log [$];

   // Transfer whose data phase is in flight
   logic        p_act;
   logic        p_wr;
   logic        p_chk;
   logic        p_err;
   logic [31:0] p_exp;
   logic [31:0] p_wdata;
   string       p_name;

   soc_top #(.ram_depth_words(ram_depth_c)) soc_top_i (
      .hclk_i(hclk), .rst_n_i(rst_n), .htrans_i(htrans), .haddr_i(haddr),
      .hwrite_i(hwrite), .hsize_i(hsize), .hwdata_i(hwdata), .hrdata_o(hrdata),
      .hready_o(hready), .hresp_o(hresp), .irq_o(irq)
   );

   initial begin
      hclk = 1'b0;
      forever #10 hclk = ~hclk;
   end

   initial begin
      cycles = 0;
      while (cycles < max_cycles_c) begin
         @(posedge hclk);
         cycles++;
      end
      $display("Run stopped at %0d cycles, a transfer never completed", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Helpers

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   function automatic int word_index(input logic [31:0] addr);
      return (addr >> 2) % ram_depth_c;
   endfunction

   function automatic logic [31:0] lane_bits(input hsize_e sz, input logic [31:0] addr);
      case (sz)
         size_byte: return 32'h0000_00FF << (8 * addr[1:0]);
         size_half: return 32'h0000_FFFF << (16 * addr[1]);
         default:   return 32'hFFFF_FFFF;
      endcase
   endfunction

   function automatic logic [31:0] timer_reg_addr(input int off);
      return tmr_base_c + 4 * off;
   endfunction

   // Finish the data phase in flight, then present the next address phase
   task automatic issue(input logic act, input logic wr, input logic [31:0] addr,
                        input hsize_e size, input logic [31:0] wdata, input logic chk,
                        input logic [31:0] exp, input logic err, input string name);
      int stalls;
      stalls = 0;
      @(negedge hclk);
      hwdata = p_wdata;
      while (!hready) begin
         stalls++;
         htrans = trans_idle;   // Cancel while the error is pending
         compare({p_name, " first resp"}, resp_error, hresp);
         @(negedge hclk);
      end
      compare({p_name, " stalls"}, p_err, stalls);
      compare({p_name, " resp"}, p_err ? resp_error : resp_okay, hresp);
      if (p_chk)
         compare(p_name, p_exp, hrdata);
      if (p_act && !p_wr && !p_err)
         rd_log.push_back(hrdata);
      htrans  = act ? trans_nonseq : trans_idle;
      haddr   = addr;
      hwrite  = wr;
      hsize   = size;
      p_act   = act;
      p_wr    = wr;
      p_chk   = chk;
      p_err   = err;
      p_exp   = exp;
      p_wdata = wdata;
      p_name  = name;
   endtask

   task automatic write_to(input logic [31:0] addr, input hsize_e size, input logic [31:0] data);
      issue(1'b1, 1'b1, addr, size, data, 1'b0, '0, 1'b0, "write");
   endtask

   task automatic read_from(input logic [31:0] addr, input logic [31:0] exp, input logic chk,
                            input string name);
      issue(1'b1, 1'b0, addr, size_word, '0, chk, exp, 1'b0, name);
   endtask

   task automatic drain_pipeline();
      issue(1'b0, 1'b0, '0, size_word, '0, 1'b0, '0, 1'b0, "idle");
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [31:0] a;
      logic [31:0] ram_a;
      logic [31:0] d;
      logic [31:0] cmp_m;
      logic [31:0] ctrl_m;
      hsize_e      sz;
      int          k;
      int          n;
      void'($urandom(32'h00ef5ac9));
      {checks, errors} = '0;
      {p_act, p_wr, p_chk, p_err, p_exp, p_wdata} = '0;
      p_name = "idle";
      rst_n  = 1'b0;
      htrans = trans_idle;
      haddr  = '0;
      hwrite = 1'b0;
      hsize  = size_word;
      hwdata = '0;
      repeat (8) @(negedge hclk);
      rst_n = 1'b1;

      // State straight out of reset
      compare("reset hready", 1'b1, hready);
      compare("reset hresp", resp_okay, hresp);
      compare("reset irq", 1'b0, irq);
      read_from(timer_reg_addr(tmr_count), 0, 1'b1, "reset count");

      for (int i = 0; i < 150; i++) begin
         if (ram_addrs.size() == 0 || $urandom_range(1, 0)) begin
            a = ram_base_c | ($urandom & 32'h1FFF_FFFC);
            d = $urandom;
            ram_m[word_index(a)] = d;
            ram_addrs.push_back(a);
            write_to(a, size_word, d);
         end else begin
            a = ram_addrs[$urandom_range(ram_addrs.size() - 1, 0)];
            read_from(a, ram_m[word_index(a)], 1'b1, "ram word");
         end
      end

      // Narrow writes merged into known words
      for (int i = 0; i < 80; i++) begin
         a = ram_addrs[$urandom_range(ram_addrs.size() - 1, 0)];
         if ($urandom_range(1, 0)) begin
            sz = size_half;
            a  = a | (2 * $urandom_range(1, 0));
         end else begin
            sz = size_byte;
            a  = a | $urandom_range(3, 0);
         end
         d = $urandom;
         ram_m[word_index(a)] = (ram_m[word_index(a)] & ~lane_bits(sz, a)) |
                                (d & lane_bits(sz, a));
         write_to(a, sz, d);
         read_from({a[31:2], 2'b00}, ram_m[word_index(a)], 1'b1, "ram lanes");
      end

      // Unmapped accesses alias known RAM words
      for (int i = 0; i < 20; i++) begin
         ram_a = ram_addrs[$urandom_range(ram_addrs.size() - 1, 0)];
         a     = ($urandom & ~idx_mask_c) | (ram_a & idx_mask_c);   // Same word index
         if (((a & ram_mask_c) == ram_base_c) || ((a & tmr_mask_c) == tmr_base_c))
            a = a ^ 32'h8000_0000;   // Out of both regions
         if (i == 0)
            a = 32'h6000_0000;
         if (i == 1)
            a = 32'h4000_0480;
         issue(1'b1, i[0], a, size_word, $urandom, 1'b0, '0, 1'b1, "unmapped");
         read_from(ram_a, ram_m[word_index(ram_a)], 1'b1, "ram after error");
      end

      // Timer registers with counting and irq off
      cmp_m  = $urandom;
      ctrl_m = $urandom & ~32'h3;
      write_to(timer_reg_addr(tmr_compare), size_word, cmp_m);
      write_to(timer_reg_addr(tmr_ctrl), size_word, ctrl_m);
      read_from(timer_reg_addr(tmr_compare), cmp_m, 1'b1, "timer compare");
      read_from(timer_reg_addr(tmr_ctrl), ctrl_m, 1'b1, "timer ctrl");
      for (int off = 4; off < 16; off++)
         read_from(timer_reg_addr(off), 0, 1'b1, "timer reserved");

      cmp_m = $urandom_range(200, 20);
      write_to(timer_reg_addr(tmr_compare), size_word, cmp_m);
      write_to(timer_reg_addr(tmr_count), size_word, 0);
      write_to(timer_reg_addr(tmr_ctrl), size_word, 32'h3);
      drain_pipeline();
      n = 0;
      while (!irq && n < cmp_m + 5) begin
         @(negedge hclk);
         n++;
      end
      if (!irq) begin
         errors++;
         $display("Timer irq never rose within %0d cycles", cmp_m + 5);
      end
      read_from(timer_reg_addr(tmr_status), 1, 1'b1, "timer status");
      write_to(timer_reg_addr(tmr_status), size_word, 1);
      drain_pipeline();
      @(negedge hclk);
      if (irq !== 1'b0) begin
         errors++;
         $display("Timer irq stayed high after STATUS was cleared");
      end

      // COUNT reads k data phases apart
      k = $urandom_range(6, 2);
      rd_log.delete();
      read_from(timer_reg_addr(tmr_count), 0, 1'b0, "count");
      repeat (k - 1)
         read_from(timer_reg_addr(tmr_compare), cmp_m, 1'b1, "timer compare");
      read_from(timer_reg_addr(tmr_count), 0, 1'b0, "count");
      drain_pipeline();
      compare("count delta", k, rd_log[k] - rd_log[0]);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- sources.f
verilog/soc_pkg.sv
verilog/ahb_slave_if.sv
verilog/ahb_decoder.sv
verilog/ahb_sram.sv
verilog/ahb_timer.sv
verilog/soc_top.sv
verif/tb_soc_top.sv
